// File: Makefile
# Verilator build for the memory subsystem testbench

TOP = tb_mem_subsystem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: design/mem_arbiter.sv
`default_nettype none

module mem_arbiter (
    input  wire              clk,
    input  wire              rst_n,

    input  wire              ireq_valid,
    output logic             ireq_ready,
    input  wire mem_pkg::addr_t  ireq_addr,
    output logic             iresp_valid,
    output mem_pkg::addr_t   iresp_addr,
    output mem_pkg::word_t   iresp_inst,

    input  wire              dreq_valid,
    output logic             dreq_ready,
    input  wire              dreq_wen,
    input  wire mem_pkg::addr_t  dreq_addr,
    input  wire mem_pkg::word_t  dreq_wdata,
    input  wire mem_pkg::wmask_t dreq_wmask,
    output logic             dresp_valid,
    output mem_pkg::addr_t   dresp_addr,
    output mem_pkg::word_t   dresp_rdata,

    mem_cmd_if.master        cmd
);
    import mem_pkg::*;

    arb_state_t state;

    logic   si_valid;  // Saved fetch pending
    addr_t  si_addr;
    logic   sd_valid;  // Saved data access pending
    logic   sd_wen;
    addr_t  sd_addr;
    word_t  sd_wdata;
    wmask_t sd_wmask;

    logic   cmd_take;

    // Fetch always goes out before the data access
    assign cmd.start = (state == WAIT_MEM_READY) && (si_valid || sd_valid);
    assign cmd.write = !si_valid && sd_valid && sd_wen;
    assign cmd.addr  = si_valid ? si_addr : sd_addr;
    assign cmd.wdata = sd_wdata;
    assign cmd.wmask = sd_wmask;
    assign cmd_take  = cmd.start && cmd.ready;

    assign ireq_ready  = (state == WAIT_CMD);
    assign dreq_ready  = (state == WAIT_CMD);

    // Read data goes to whichever side is outstanding
    assign iresp_valid = (state == WAIT_MEM_READ_VALID) && cmd.rdata_valid && si_valid;
    assign iresp_addr  = si_addr;
    assign iresp_inst  = cmd.rdata;
    assign dresp_valid = (state == WAIT_MEM_READ_VALID) && cmd.rdata_valid && !si_valid;
    assign dresp_addr  = sd_addr;
    assign dresp_rdata = cmd.rdata;

    always_ff @(posedge clk) begin
        if (state == WAIT_CMD) begin  // Capture both request payloads
            si_addr  <= ireq_addr;
            sd_wen   <= dreq_wen;
            sd_addr  <= dreq_addr;
            sd_wdata <= dreq_wdata;
            sd_wmask <= dreq_wmask;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= WAIT_CMD;
            si_valid <= 1'b0;
            sd_valid <= 1'b0;
        end else begin
            case (state)
                WAIT_CMD: begin
                    si_valid <= ireq_valid;
                    sd_valid <= dreq_valid;
                    if (ireq_valid || dreq_valid)
                        state <= WAIT_MEM_READY;
                end
                WAIT_MEM_READY: begin
                    if (cmd_take) begin
                        if (si_valid) begin
                            state <= WAIT_MEM_READ_VALID;
                        end else if (sd_wen) begin
                            sd_valid <= 1'b0;  // Writes get no answer
                            state    <= WAIT_CMD;
                        end else begin
                            state <= WAIT_MEM_READ_VALID;
                        end
                    end
                end
                WAIT_MEM_READ_VALID: begin
                    if (cmd.rdata_valid) begin
                        if (si_valid) begin
                            si_valid <= 1'b0;
                            state    <= sd_valid ? WAIT_MEM_READY : WAIT_CMD;
                        end else begin
                            sd_valid <= 1'b0;
                            state    <= WAIT_CMD;
                        end
                    end
                end
                default: state <= WAIT_CMD;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/mem_cmd_if.sv
`default_nettype none

interface mem_cmd_if;
    import mem_pkg::*;

    logic   start;        // Command strobe
    logic   write;
    addr_t  addr;
    word_t  wdata;
    wmask_t wmask;
    logic   ready;        // Controller can take a command
    word_t  rdata;
    logic   rdata_valid;  // One pulse per read

    modport master (
        output start, write, addr, wdata, wmask,
        input  ready, rdata, rdata_valid
    );

    modport slave (
        input  start, write, addr, wdata, wmask,
        output ready, rdata, rdata_valid
    );

endinterface

`default_nettype wire

// File: design/mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// Byte address width of the memory side
`define MEM_ADDR_W 32

// RAM depth in 32-bit words
`define MEM_WORDS 1024

// Cycles from an accepted RAM read to its data
`define RAM_LATENCY 2

// Start of the timer register block
`define TIMER_BASE 32'h4000_0000

`endif

// File: design/mem_map_controller.sv
`default_nettype none
`include "mem_defines.svh"

module mem_map_controller (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire mem_pkg::time_t mtime,
    output mem_pkg::time_t      mtimecmp,
    mem_cmd_if.slave            cmd
);
    import mem_pkg::*;

    localparam int    IDX_W      = $clog2(`MEM_WORDS);
    localparam addr_t TIMER_BASE = `TIMER_BASE;

    logic       take;
    logic       ram_sel;
    logic       timer_sel;
    logic [1:0] timer_off;    // Word offset inside the timer block
    logic       busy;         // Read in flight
    logic       local_valid;
    word_t      local_rdata;
    word_t      timer_word;
    word_t      ram_rdata;
    logic       ram_rvalid;

    assign take      = cmd.start && cmd.ready;
    assign ram_sel   = (cmd.addr[`MEM_ADDR_W-1 -: 2] == 2'b00);
    assign timer_sel = (cmd.addr[`MEM_ADDR_W-1:4] == TIMER_BASE[`MEM_ADDR_W-1:4]);
    assign timer_off = cmd.addr[3:2];

    assign cmd.ready = !busy;

    always_comb begin
        case (timer_off)
            2'd0:    timer_word = mtimecmp[31:0];
            2'd1:    timer_word = mtimecmp[63:32];
            2'd2:    timer_word = mtime[31:0];
            default: timer_word = mtime[63:32];
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (cmd.rdata_valid) begin
            busy <= 1'b0;
        end else if (take && !cmd.write) begin
            busy <= 1'b1;
        end
    end

    // Timer and unmapped reads answer one cycle after acceptance
    always_ff @(posedge clk) begin
        if (!rst_n)
            local_valid <= 1'b0;
        else
            local_valid <= take && !cmd.write && !ram_sel;
    end

    always_ff @(posedge clk) begin
        if (take && !cmd.write)
            local_rdata <= timer_sel ? timer_word : '0;  // Unmapped reads as zero
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtimecmp <= '1;  // No interrupt until software programs it
        end else if (take && cmd.write && timer_sel && !timer_off[1]) begin
            for (int b = 0; b < 8; b++) begin
                if (cmd.wmask[b % 4] && (b / 4 == int'(timer_off[0])))
                    mtimecmp[8*b +: 8] <= cmd.wdata[8*(b % 4) +: 8];
            end
        end
    end

    ram_bank u_ram (
        .clk    (clk),
        .rst_n  (rst_n),
        .en     (take && ram_sel),
        .we     (cmd.write),
        .index  (cmd.addr[IDX_W+1:2]),  // Upper RAM bits alias
        .wdata  (cmd.wdata),
        .wmask  (cmd.wmask),
        .rdata  (ram_rdata),
        .rvalid (ram_rvalid)
    );

    assign cmd.rdata       = ram_rvalid ? ram_rdata : local_rdata;
    assign cmd.rdata_valid = ram_rvalid || local_valid;

endmodule

`default_nettype wire

// File: design/mem_pkg.sv
`default_nettype none
`include "mem_defines.svh"

package mem_pkg;

    typedef logic [`MEM_ADDR_W-1:0] addr_t;  // Byte address
    typedef logic [31:0] word_t;             // Data word or instruction
    typedef logic [3:0] wmask_t;             // Bit n enables byte n
    typedef logic [63:0] time_t;             // mtime / mtimecmp

    typedef enum logic [1:0] {
        WAIT_CMD,
        WAIT_MEM_READY,
        WAIT_MEM_READ_VALID
    } arb_state_t;

endpackage

`default_nettype wire

// File: design/mem_subsystem.sv
`default_nettype none

module mem_subsystem (
    input  wire                  clk,
    input  wire                  rst_n,

    input  wire                  ireq_valid,
    output wire                  ireq_ready,
    input  wire mem_pkg::addr_t  ireq_addr,
    output wire                  iresp_valid,
    output wire mem_pkg::addr_t  iresp_addr,
    output wire mem_pkg::word_t  iresp_inst,

    input  wire                  dreq_valid,
    output wire                  dreq_ready,
    input  wire                  dreq_wen,
    input  wire mem_pkg::addr_t  dreq_addr,
    input  wire mem_pkg::word_t  dreq_wdata,
    input  wire mem_pkg::wmask_t dreq_wmask,
    output wire                  dresp_valid,
    output wire mem_pkg::addr_t  dresp_addr,
    output wire mem_pkg::word_t  dresp_rdata,

    input  wire mem_pkg::time_t  mtime,
    output wire mem_pkg::time_t  mtimecmp
);

    mem_cmd_if cmd_bus ();  // Arbiter to map controller

    mem_arbiter u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .ireq_valid  (ireq_valid),
        .ireq_ready  (ireq_ready),
        .ireq_addr   (ireq_addr),
        .iresp_valid (iresp_valid),
        .iresp_addr  (iresp_addr),
        .iresp_inst  (iresp_inst),
        .dreq_valid  (dreq_valid),
        .dreq_ready  (dreq_ready),
        .dreq_wen    (dreq_wen),
        .dreq_addr   (dreq_addr),
        .dreq_wdata  (dreq_wdata),
        .dreq_wmask  (dreq_wmask),
        .dresp_valid (dresp_valid),
        .dresp_addr  (dresp_addr),
        .dresp_rdata (dresp_rdata),
        .cmd         (cmd_bus.master)
    );

    mem_map_controller u_map_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .mtime    (mtime),
        .mtimecmp (mtimecmp),
        .cmd      (cmd_bus.slave)
    );

endmodule

`default_nettype wire

// File: design/ram_bank.sv
`default_nettype none
`include "mem_defines.svh"

module ram_bank (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         en,
    input  wire                         we,
    input  wire [$clog2(`MEM_WORDS)-1:0] index,
    input  wire mem_pkg::word_t         wdata,
    input  wire mem_pkg::wmask_t        wmask,
    output mem_pkg::word_t              rdata,
    output logic                        rvalid
);
    import mem_pkg::*;

    localparam int LAT = `RAM_LATENCY;

    word_t          mem [`MEM_WORDS];
    word_t          data_pipe [LAT];
    logic [LAT-1:0] vld_pipe;

    always_ff @(posedge clk) begin
        if (en && we) begin
            for (int b = 0; b < 4; b++) begin
                if (wmask[b])
                    mem[index][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

    // Read data pipeline
    always_ff @(posedge clk) begin
        data_pipe[0] <= mem[index];
        for (int i = 1; i < LAT; i++)
            data_pipe[i] <= data_pipe[i-1];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= en && !we;
            for (int i = 1; i < LAT; i++)
                vld_pipe[i] <= vld_pipe[i-1];
        end
    end

    assign rdata  = data_pipe[LAT-1];
    assign rvalid = vld_pipe[LAT-1];

endmodule

`default_nettype wire

// File: verification/tb_mem_subsystem.sv
`default_nettype none
`include "mem_defines.svh"

module tb_mem_subsystem;
    timeunit 1ns;
    timeprecision 100ps;
    import mem_pkg::*;

    localparam int TIMEOUT = 50;  // Cycles per wait

    logic   clk = 1'b0;
    logic   rst_n;
    logic   ireq_valid;
    logic   ireq_ready;
    addr_t  ireq_addr;
    logic   iresp_valid;
    addr_t  iresp_addr;
    word_t  iresp_inst;
    logic   dreq_valid;
    logic   dreq_ready;
    logic   dreq_wen;
    addr_t  dreq_addr;
    word_t  dreq_wdata;
    wmask_t dreq_wmask;
    logic   dresp_valid;
    addr_t  dresp_addr;
    word_t  dresp_rdata;
    time_t  mtime = 64'h0000_0012_FFFF_FFF0;  // Low half wraps early
    time_t  mtimecmp;

    word_t  ram_model [int];  // Keyed by word index
    time_t  cmp_model;
    word_t  rng_state = 32'd45698;
    word_t  resp_data;
    addr_t  resp_addr;
    time_t  resp_time;        // mtime seen with the response
    int     errors;
    int     test_errors;
    int     checks;
    int     tests;

    always #2 clk = ~clk;

    always @(posedge clk) mtime <= mtime + 64'd1;

    mem_subsystem dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .ireq_valid  (ireq_valid),
        .ireq_ready  (ireq_ready),
        .ireq_addr   (ireq_addr),
        .iresp_valid (iresp_valid),
        .iresp_addr  (iresp_addr),
        .iresp_inst  (iresp_inst),
        .dreq_valid  (dreq_valid),
        .dreq_ready  (dreq_ready),
        .dreq_wen    (dreq_wen),
        .dreq_addr   (dreq_addr),
        .dreq_wdata  (dreq_wdata),
        .dreq_wmask  (dreq_wmask),
        .dresp_valid (dresp_valid),
        .dresp_addr  (dresp_addr),
        .dresp_rdata (dresp_rdata),
        .mtime       (mtime),
        .mtimecmp    (mtimecmp)
    );

    function automatic word_t next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic word_t merge_bytes(word_t old, word_t wdata, wmask_t mask);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b])
                res[8*b +: 8] = wdata[8*b +: 8];
        end
        return res;
    endfunction

    function automatic int word_index(addr_t a);
        return int'(a[11:2]);  // Upper RAM bits alias
    endfunction

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic report_problem(string msg);
        $display("At %0t ns: %s", $time, msg);
        test_errors++;
    endtask

    task automatic finish_test(string name);
        tests++;
        $display("Test %0d %s: %0d errors", tests, name, test_errors);
        errors += test_errors;
        test_errors = 0;
    endtask

    // Holds valid until the arbiter captures the request
    task automatic send_request(logic do_i, addr_t iaddr, logic do_d, logic wen,
                                addr_t daddr, word_t wdata, wmask_t mask);
        int n;
        @(posedge clk);
        ireq_valid <= do_i;
        ireq_addr  <= iaddr;
        dreq_valid <= do_d;
        dreq_wen   <= wen;
        dreq_addr  <= daddr;
        dreq_wdata <= wdata;
        dreq_wmask <= mask;
        n = 0;
        @(negedge clk);
        while (((do_i && !ireq_ready) || (do_d && !dreq_ready)) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if ((do_i && !ireq_ready) || (do_d && !dreq_ready))
            report_problem("timeout waiting for request ready");
        @(posedge clk);
        ireq_valid <= 1'b0;
        dreq_valid <= 1'b0;
    endtask

    task automatic wait_response(logic inst_side);
        int   n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < TIMEOUT) begin
            @(negedge clk);
            n++;
            if (ireq_ready || dreq_ready)
                report_problem("request ready high while an access is in flight");
            if (inst_side ? dresp_valid : iresp_valid)
                report_problem("response pulse on the wrong port");
            if (inst_side ? iresp_valid : dresp_valid) begin
                seen = 1'b1;
                resp_data = inst_side ? iresp_inst : dresp_rdata;
                resp_addr = inst_side ? iresp_addr : dresp_addr;
                resp_time = mtime;
            end
        end
        if (!seen)
            report_problem("timeout waiting for a response pulse");
    endtask

    // A write ends when ready comes back
    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (!dreq_ready && n < TIMEOUT) begin
            if (iresp_valid || dresp_valid)
                report_problem("response pulse after a write");
            @(negedge clk);
            n++;
        end
        if (!dreq_ready)
            report_problem("timeout waiting for ready after a write");
    endtask

    task automatic data_write(addr_t a, word_t wdata, wmask_t mask);
        send_request(1'b0, '0, 1'b1, 1'b1, a, wdata, mask);
        wait_idle();
    endtask

    task automatic data_read(addr_t a);
        send_request(1'b0, '0, 1'b1, 1'b0, a, '0, '0);
        wait_response(1'b0);
        check_value("dresp_addr", 64'(resp_addr), 64'(a));
    endtask

    task automatic fetch(addr_t a);
        send_request(1'b1, a, 1'b0, 1'b0, '0, '0, '0);
        wait_response(1'b1);
        check_value("iresp_addr", 64'(resp_addr), 64'(a));
    endtask

    initial begin
        addr_t  addrs [16];
        addr_t  a;
        word_t  r;
        time_t  exp_t;
        int     i;
        int     j;
        rst_n      <= 1'b0;
        ireq_valid <= 1'b0;
        ireq_addr  <= '0;
        dreq_valid <= 1'b0;
        dreq_wen   <= 1'b0;
        dreq_addr  <= '0;
        dreq_wdata <= '0;
        dreq_wmask <= '0;
        cmp_model = '1;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        check_value("ireq_ready", 64'(ireq_ready), 64'd1);
        check_value("dreq_ready", 64'(dreq_ready), 64'd1);
        check_value("iresp_valid", 64'(iresp_valid), 64'd0);
        check_value("dresp_valid", 64'(dresp_valid), 64'd0);
        check_value("mtimecmp", mtimecmp, cmp_model);
        finish_test("reset values");

        for (i = 0; i < 16; i++) begin  // Full words first so every byte is known
            addrs[i] = next_rand() & 32'h3FFF_FFFC;
            r = next_rand();
            data_write(addrs[i], r, 4'hF);
            ram_model[word_index(addrs[i])] = r;
        end
        for (i = 0; i < 16; i++) begin
            r = next_rand();
            a = addrs[int'(r[7:4])];
            data_write(a, next_rand(), r[3:0]);
            ram_model[word_index(a)] = merge_bytes(ram_model[word_index(a)],
                                                   dreq_wdata, r[3:0]);
        end
        for (i = 0; i < 16; i++) begin
            data_read(addrs[i]);
            check_value("dresp_rdata", 64'(resp_data), 64'(ram_model[word_index(addrs[i])]));
        end
        finish_test("masked RAM writes and reads");

        for (i = 0; i < 16; i++) begin
            fetch(addrs[i]);
            check_value("iresp_inst", 64'(resp_data), 64'(ram_model[word_index(addrs[i])]));
        end
        finish_test("instruction fetch");

        for (int k = 0; k < 8; k++) begin
            r = next_rand();
            i = int'(r[3:0]);
            j = int'(r[7:4]);
            send_request(1'b1, addrs[i], 1'b1, 1'b0, addrs[j], '0, '0);
            wait_response(1'b1);  // Fetch is served first
            check_value("iresp_inst", 64'(resp_data), 64'(ram_model[word_index(addrs[i])]));
            wait_response(1'b0);
            check_value("dresp_rdata", 64'(resp_data), 64'(ram_model[word_index(addrs[j])]));
            check_value("dresp_addr", 64'(resp_addr), 64'(addrs[j]));
        end
        finish_test("same-cycle fetch and data read");

        for (i = 0; i < 6; i++) begin
            r = next_rand();
            a = r[8] ? `TIMER_BASE + 32'd4 : `TIMER_BASE;
            data_write(a, dreq_wdata ^ next_rand(), r[3:0]);
            if (r[8])
                cmp_model[63:32] = merge_bytes(cmp_model[63:32], dreq_wdata, r[3:0]);
            else
                cmp_model[31:0] = merge_bytes(cmp_model[31:0], dreq_wdata, r[3:0]);
            check_value("mtimecmp", mtimecmp, cmp_model);
        end
        data_read(`TIMER_BASE);
        check_value("mtimecmp low read", 64'(resp_data), 64'(cmp_model[31:0]));
        data_read(`TIMER_BASE + 32'd4);
        check_value("mtimecmp high read", 64'(resp_data), 64'(cmp_model[63:32]));
        for (i = 0; i < 4; i++) begin
            data_read(`TIMER_BASE + 32'd8);
            exp_t = resp_time - 64'd1;  // Counter moved on at the take edge
            check_value("mtime low read", 64'(resp_data), 64'(exp_t[31:0]));
            data_read(`TIMER_BASE + 32'd12);
            exp_t = resp_time - 64'd1;
            check_value("mtime high read", 64'(resp_data), 64'(exp_t[63:32]));
        end
        finish_test("timer registers");

        for (i = 0; i < 8; i++) begin
            r = next_rand();
            if (r[0])
                a = 32'h8000_0000 | (next_rand() & 32'h7FFF_FFFC);
            else
                a = 32'h4000_0010 | (next_rand() & 32'h00FF_FFFC);  // Above the timer block
            data_write(a, next_rand(), 4'hF);
            data_read(a);
            check_value("unmapped dresp_rdata", 64'(resp_data), 64'd0);
        end
        check_value("mtimecmp", mtimecmp, cmp_model);
        for (i = 0; i < 16; i++) begin
            data_read(addrs[i]);
            check_value("dresp_rdata", 64'(resp_data), 64'(ram_model[word_index(addrs[i])]));
        end
        finish_test("unmapped accesses");

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+design
design/mem_pkg.sv
design/mem_cmd_if.sv
design/ram_bank.sv
design/mem_map_controller.sv
design/mem_arbiter.sv
design/mem_subsystem.sv
verification/tb_mem_subsystem.sv
